//--- src/lsu_pkg.sv
// LSU package with memory map, access sizes and pipeline payload types
`default_nettype none

package lsu_pkg;

   // ****************************************
   // Widths
   // ****************************************
   localparam int XLEN       = 32;
   localparam int OFFSET_W   = 12;
   localparam int DMA_DATA_W = 64;

   // ****************************************
   // Memory map
   // ****************************************
   localparam logic [XLEN-1:0] DCCM_BASE       = 32'hf004_0000;
   localparam logic [XLEN-1:0] DCCM_SIZE_BYTES = 32'h0001_0000;
   localparam logic [XLEN-1:0] PIC_BASE        = 32'hf00c_0000;
   localparam logic [XLEN-1:0] PIC_SIZE_BYTES  = 32'h0000_8000;

   // DMA size codes, low two bits of the 3-bit size field
   typedef enum logic [1:0] {
      SIZE_BYTE  = 2'd0,
      SIZE_HALF  = 2'd1,
      SIZE_WORD  = 2'd2,
      SIZE_DWORD = 2'd3
   } lsu_size_e;

   // Control packet, one size bit set per access
   typedef struct packed {
      logic valid;
      logic dma;
      logic unsign;
      logic store;
      logic load;
      logic by;
      logic half;
      logic word;
      logic dword;
   } lsu_pkt_t;

   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
      logic access_fault;
      logic misaligned_fault;
   } lsu_region_t;

   // DC1 to DC3 payload
   typedef struct packed {
      lsu_pkt_t                pkt;
      logic [XLEN-1:0]         addr;
      logic [XLEN-1:0]         end_addr;
      logic [DMA_DATA_W-1:0]   store_data;
      lsu_region_t             region;
   } lsu_dc_t;

   // DC4 and DC5 payload, store data narrowed to one word
   typedef struct packed {
      lsu_pkt_t                pkt;
      logic [XLEN-1:0]         addr;
      logic [XLEN-1:0]         end_addr;
      logic [XLEN-1:0]         store_data;
   } lsu_wb_t;

   typedef struct packed {
      logic              exc_valid;
      logic              single_ecc_error;
      logic              inst_type;
      logic              dma_valid;
      logic              exc_type;
      logic [XLEN-1:0]   addr;
   } lsu_error_pkt_t;

endpackage

`default_nettype wire

//--- src/lsu_issue_stage.sv
// DC1 entry stage merging core and DMA requests into the first pipeline register
`timescale 1ns/10ps
`default_nettype none

module lsu_issue_stage
   import lsu_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,

   // Core request
   input  lsu_pkt_t                lsu_p,
   input  logic [XLEN-1:0]         exu_lsu_rs1_d,
   input  logic [XLEN-1:0]         exu_lsu_rs2_d,
   input  logic [OFFSET_W-1:0]     dec_lsu_offset_d,

   // DMA request
   input  logic                    dma_dccm_req,
   input  logic [XLEN-1:0]         dma_mem_addr,
   input  logic [2:0]              dma_mem_sz,
   input  logic                    dma_mem_write,
   input  logic [DMA_DATA_W-1:0]   dma_mem_wdata,

   input  logic                    flush_dc2_up,

   output lsu_pkt_t                pkt_dc1,
   output logic [XLEN-1:0]         rs1_dc1,
   output logic [OFFSET_W-1:0]     offset_dc1,
   output logic [DMA_DATA_W-1:0]   store_data_dc1
);

   lsu_pkt_t                dma_pkt_d;
   lsu_pkt_t                pkt_d;
   logic [XLEN-1:0]         rs1_d;
   logic [OFFSET_W-1:0]     offset_d;
   logic [DMA_DATA_W-1:0]   dma_wdata_shifted;
   logic [DMA_DATA_W-1:0]   store_data_d;
   lsu_size_e               dma_size;

   // ****************************************
   // DMA packet
   // ****************************************
   assign dma_size = lsu_size_e'(dma_mem_sz[1:0]);

   always_comb begin
      dma_pkt_d        = '0;
      dma_pkt_d.valid  = dma_dccm_req;
      dma_pkt_d.dma    = 1'b1;
      dma_pkt_d.store  = dma_mem_write;
      dma_pkt_d.load   = ~dma_mem_write;
      dma_pkt_d.by     = ~dma_mem_sz[2] & (dma_size == SIZE_BYTE);
      dma_pkt_d.half   = ~dma_mem_sz[2] & (dma_size == SIZE_HALF);
      dma_pkt_d.word   = ~dma_mem_sz[2] & (dma_size == SIZE_WORD);
      dma_pkt_d.dword  = ~dma_mem_sz[2] & (dma_size == SIZE_DWORD);
   end

   // DMA wins, a core request in the same cycle is dropped
   always_comb begin
      pkt_d       = dma_dccm_req ? dma_pkt_d : lsu_p;
      pkt_d.valid = (lsu_p.valid & ~flush_dc2_up) | dma_dccm_req;
   end

   assign rs1_d    = dma_dccm_req ? dma_mem_addr : exu_lsu_rs1_d;
   assign offset_d = dec_lsu_offset_d & ~{OFFSET_W{dma_dccm_req}};

   // Align DMA write data to the byte lane of its address
   assign dma_wdata_shifted = dma_mem_wdata >> {dma_mem_addr[2:0], 3'b000};
   assign store_data_d      = dma_dccm_req ? dma_wdata_shifted
                                           : {{(DMA_DATA_W-XLEN){1'b0}}, exu_lsu_rs2_d};

   always_ff @(posedge clk) begin
      pkt_dc1        <= pkt_d;
      rs1_dc1        <= rs1_d;
      offset_dc1     <= offset_d;
      store_data_dc1 <= store_data_d;
      if (rst) begin
         pkt_dc1.valid <= 1'b0;
      end
   end

   // Core packets must carry a single size as well
   a_dc1_one_size : assert property (@(posedge clk) disable iff (rst)
      pkt_dc1.valid |-> $onehot0({pkt_dc1.by, pkt_dc1.half, pkt_dc1.word, pkt_dc1.dword}));

endmodule

`default_nettype wire

//--- src/lsu_addr_stage.sv
// DC1 address generation, memory-map decode and fault detection
`timescale 1ns/10ps
`default_nettype none

module lsu_addr_stage
   import lsu_pkg::*;
(
   input  lsu_pkt_t                pkt_dc1,
   input  logic [XLEN-1:0]         rs1_dc1,
   input  logic [OFFSET_W-1:0]     offset_dc1,
   input  logic [DMA_DATA_W-1:0]   store_data_dc1,

   output lsu_dc_t                 stage_dc1
);

   logic [XLEN-1:0]   addr_dc1;
   logic [XLEN-1:0]   end_addr_dc1;
   logic [2:0]        size_off_dc1;
   logic              start_in_dccm;
   logic              start_in_pic;
   logic              end_in_dccm;
   logic              end_in_pic;
   logic              unaligned;
   lsu_region_t       region_dc1;

   function automatic logic in_range(
      input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] base,
      input logic [XLEN-1:0] size
   );
      return (a >= base) && (a <= base + size - 32'd1);
   endfunction

   // ****************************************
   // Start and end address
   // ****************************************
   assign addr_dc1 = rs1_dc1 + {{(XLEN-OFFSET_W){offset_dc1[OFFSET_W-1]}}, offset_dc1};

   // Last byte touched is size minus one past the start
   assign size_off_dc1 = ({3{pkt_dc1.half}}  & 3'b001) |
                         ({3{pkt_dc1.word}}  & 3'b011) |
                         ({3{pkt_dc1.dword}} & 3'b111);

   assign end_addr_dc1 = addr_dc1 + {{(XLEN-3){1'b0}}, size_off_dc1};

   // ****************************************
   // Region decode
   // ****************************************
   assign start_in_dccm = in_range(addr_dc1, DCCM_BASE, DCCM_SIZE_BYTES);
   assign start_in_pic  = in_range(addr_dc1, PIC_BASE, PIC_SIZE_BYTES);
   assign end_in_dccm   = in_range(end_addr_dc1, DCCM_BASE, DCCM_SIZE_BYTES);
   assign end_in_pic    = in_range(end_addr_dc1, PIC_BASE, PIC_SIZE_BYTES);

   // Start not on a multiple of the access size
   assign unaligned = (pkt_dc1.half  & addr_dc1[0]) |
                      (pkt_dc1.word  & (addr_dc1[1:0] != 2'b00)) |
                      (pkt_dc1.dword & (addr_dc1[2:0] != 3'b000));

   always_comb begin
      region_dc1.in_dccm  = start_in_dccm;
      region_dc1.in_pic   = start_in_pic;
      region_dc1.external = ~start_in_dccm & ~start_in_pic;

      // Crossing a region edge, or a PIC access other than a word
      region_dc1.access_fault = (start_in_dccm != end_in_dccm) |
                                (start_in_pic != end_in_pic) |
                                (start_in_pic & ~pkt_dc1.word);

      // DCCM handles unaligned accesses itself
      region_dc1.misaligned_fault = unaligned & ~start_in_dccm;
   end

   always_comb begin
      stage_dc1.pkt        = pkt_dc1;
      stage_dc1.addr       = addr_dc1;
      stage_dc1.end_addr   = end_addr_dc1;
      stage_dc1.store_data = store_data_dc1;
      stage_dc1.region     = region_dc1;
   end

endmodule

`default_nettype wire

//--- src/lsu_stage_reg.sv
// Pipeline stage register with flush kill of non-DMA packets
`timescale 1ns/10ps
`default_nettype none

module lsu_stage_reg
   import lsu_pkg::*;
#(
   // Any payload carrying a pkt field of type lsu_pkt_t
   parameter type payload_t = lsu_dc_t
)(
   input  logic       clk,
   input  logic       rst,
   input  payload_t   din,
   input  logic       kill,
   output payload_t   dout
);

   payload_t   din_killed;

   // DMA transfers are not owned by the core and survive flushes
   always_comb begin
      din_killed           = din;
      din_killed.pkt.valid = din.pkt.valid & ~(kill & ~din.pkt.dma);
   end

   // ****************************************
   // Stage flops
   // ****************************************
   always_ff @(posedge clk) begin
      dout <= din_killed;
      if (rst) begin
         dout.pkt.valid <= 1'b0;
      end
   end

   a_kill_drops_item : assert property (@(posedge clk) disable iff (rst)
      (kill && din.pkt.valid && !din.pkt.dma) |=> !dout.pkt.valid);

endmodule

`default_nettype wire

//--- src/lsu_result_stage.sv
// DC3 load data formatting and exception packet generation
`timescale 1ns/10ps
`default_nettype none

module lsu_result_stage
   import lsu_pkg::*;
(
   input  lsu_dc_t          stage_dc3,
   input  logic [XLEN-1:0]  lsu_ld_data_dc3,
   input  logic [XLEN-1:0]  bus_read_data_dc3,
   input  logic             ld_bus_error_dc3,
   input  logic             flush_dc3,

   output logic [XLEN-1:0]  lsu_result_dc3,
   output lsu_error_pkt_t   lsu_error_pkt_dc3
);

   lsu_pkt_t          pkt_dc3;
   logic [XLEN-1:0]   ld_data_dc3;
   logic              any_fault_dc3;

   assign pkt_dc3 = stage_dc3.pkt;

   // ****************************************
   // Load result
   // ****************************************
   // External loads return over the bus, the rest from DCCM
   assign ld_data_dc3 = stage_dc3.region.external ? bus_read_data_dc3 : lsu_ld_data_dc3;

   always_comb begin
      if (pkt_dc3.by) begin
         lsu_result_dc3 = {{(XLEN-8){~pkt_dc3.unsign & ld_data_dc3[7]}}, ld_data_dc3[7:0]};
      end else if (pkt_dc3.half) begin
         lsu_result_dc3 = {{(XLEN-16){~pkt_dc3.unsign & ld_data_dc3[15]}},
                           ld_data_dc3[15:0]};
      end else if (pkt_dc3.word) begin
         lsu_result_dc3 = ld_data_dc3;
      end else begin
         // dword only comes from DMA, no register result
         lsu_result_dc3 = '0;
      end
   end

   // ****************************************
   // Exception packet
   // ****************************************
   assign any_fault_dc3 = stage_dc3.region.access_fault |
                          stage_dc3.region.misaligned_fault |
                          ld_bus_error_dc3;

   always_comb begin
      lsu_error_pkt_dc3.exc_valid        = any_fault_dc3 & pkt_dc3.valid & ~pkt_dc3.dma &
                                           ~flush_dc3;
      lsu_error_pkt_dc3.single_ecc_error = 1'b0;
      lsu_error_pkt_dc3.inst_type        = pkt_dc3.store;
      lsu_error_pkt_dc3.dma_valid        = pkt_dc3.dma;
      // 0 for misaligned, 1 for access and bus errors
      lsu_error_pkt_dc3.exc_type         = ~stage_dc3.region.misaligned_fault;
      lsu_error_pkt_dc3.addr             = stage_dc3.addr;
   end

endmodule

`default_nettype wire

//--- src/lsu_ctl.sv
// LSU control pipeline top, carrying requests from DC1 through DC5 to commit
`timescale 1ns/10ps
`default_nettype none

module lsu_ctl
   import lsu_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,

   // Core request
   input  lsu_pkt_t                lsu_p,
   input  logic [XLEN-1:0]         exu_lsu_rs1_d,
   input  logic [XLEN-1:0]         exu_lsu_rs2_d,
   input  logic [OFFSET_W-1:0]     dec_lsu_offset_d,

   // DMA request
   input  logic                    dma_dccm_req,
   input  logic [XLEN-1:0]         dma_mem_addr,
   input  logic [2:0]              dma_mem_sz,
   input  logic                    dma_mem_write,
   input  logic [DMA_DATA_W-1:0]   dma_mem_wdata,

   // Flushes per stage
   input  logic                    flush_dc2_up,
   input  logic                    flush_dc3,
   input  logic                    flush_dc4,
   input  logic                    flush_dc5,

   // Load return
   input  logic [XLEN-1:0]         lsu_ld_data_dc3,
   input  logic [XLEN-1:0]         bus_read_data_dc3,
   input  logic                    ld_bus_error_dc3,

   output logic [XLEN-1:0]         lsu_addr_dc3,
   output logic [XLEN-1:0]         end_addr_dc3,
   output logic [XLEN-1:0]         store_data_dc3,
   output logic [XLEN-1:0]         store_data_dc5,
   output lsu_pkt_t                lsu_pkt_dc3,
   output logic                    addr_external_dc3,
   output logic [XLEN-1:0]         lsu_result_dc3,
   output logic                    lsu_exc_dc2,
   output lsu_error_pkt_t          lsu_error_pkt_dc3,
   output logic [XLEN-1:0]         lsu_addr_dc5,
   output logic                    lsu_commit_dc5
);

   lsu_pkt_t                pkt_dc1;
   logic [XLEN-1:0]         rs1_dc1;
   logic [OFFSET_W-1:0]     offset_dc1;
   logic [DMA_DATA_W-1:0]   store_data_dc1;
   lsu_dc_t                 stage_dc1, stage_dc2, stage_dc3;
   lsu_wb_t                 wb_dc3, wb_dc4, wb_dc5;

   // ****************************************
   // DC1
   // ****************************************
   lsu_issue_stage u_issue (.*);

   lsu_addr_stage u_addr (.*);

   // ****************************************
   // DC2 and DC3
   // ****************************************
   lsu_stage_reg #(.payload_t(lsu_dc_t)) u_dc2_reg (
      .clk(clk), .rst(rst), .din(stage_dc1), .kill(flush_dc2_up), .dout(stage_dc2));

   lsu_stage_reg #(.payload_t(lsu_dc_t)) u_dc3_reg (
      .clk(clk), .rst(rst), .din(stage_dc2), .kill(flush_dc2_up), .dout(stage_dc3));

   assign lsu_exc_dc2 = stage_dc2.region.access_fault | stage_dc2.region.misaligned_fault;

   lsu_result_stage u_result (.*);

   assign lsu_pkt_dc3       = stage_dc3.pkt;
   assign lsu_addr_dc3      = stage_dc3.addr;
   assign end_addr_dc3      = stage_dc3.end_addr;
   assign store_data_dc3    = stage_dc3.store_data[XLEN-1:0];
   assign addr_external_dc3 = stage_dc3.region.external;

   // ****************************************
   // DC4 and DC5
   // ****************************************
   // Late stages keep only the low store word
   always_comb begin
      wb_dc3.pkt        = stage_dc3.pkt;
      wb_dc3.addr       = stage_dc3.addr;
      wb_dc3.end_addr   = stage_dc3.end_addr;
      wb_dc3.store_data = stage_dc3.store_data[XLEN-1:0];
   end

   lsu_stage_reg #(.payload_t(lsu_wb_t)) u_dc4_reg (
      .clk(clk), .rst(rst), .din(wb_dc3), .kill(flush_dc3), .dout(wb_dc4));

   lsu_stage_reg #(.payload_t(lsu_wb_t)) u_dc5_reg (
      .clk(clk), .rst(rst), .din(wb_dc4), .kill(flush_dc4), .dout(wb_dc5));

   assign lsu_addr_dc5   = wb_dc5.addr;
   assign store_data_dc5 = wb_dc5.store_data;

   // One strobe per surviving core access
   assign lsu_commit_dc5 = wb_dc5.pkt.valid & (wb_dc5.pkt.load | wb_dc5.pkt.store) &
                           ~wb_dc5.pkt.dma & ~flush_dc5;

endmodule

`default_nettype wire

//--- verification/lsu_ctl_tb.sv
// Testbench for the LSU control pipeline, with a reference model checked by assertions
`timescale 1ns/10ps
`default_nettype none

module lsu_ctl_tb
   import lsu_pkg::*;
();

   // Expected item as it travels down the model pipeline
   typedef struct packed {
      logic          valid;
      logic          dma;
      logic          load;
      logic          unsign;
      logic [2:0]    szm1;
      logic [31:0]   addr;
      logic [31:0]   end_addr;
      logic [63:0]   wdata;
      logic          ext;
      logic          afault;
      logic          mfault;
   } item_t;

   logic clk, rst;
   lsu_pkt_t lsu_p;
   logic [XLEN-1:0] exu_lsu_rs1_d, exu_lsu_rs2_d, dma_mem_addr;
   logic [OFFSET_W-1:0] dec_lsu_offset_d;
   logic dma_dccm_req, dma_mem_write;
   logic [2:0] dma_mem_sz;
   logic [DMA_DATA_W-1:0] dma_mem_wdata;
   logic flush_dc2_up, flush_dc3, flush_dc4, flush_dc5;
   logic [XLEN-1:0] lsu_ld_data_dc3, bus_read_data_dc3;
   logic ld_bus_error_dc3;
   logic [XLEN-1:0] lsu_addr_dc3, end_addr_dc3, store_data_dc3, store_data_dc5;
   logic [XLEN-1:0] lsu_result_dc3, lsu_addr_dc5;
   lsu_pkt_t lsu_pkt_dc3;
   lsu_error_pkt_t lsu_error_pkt_dc3;
   logic addr_external_dc3, lsu_exc_dc2, lsu_commit_dc5;

   item_t exp_q [1:5];
   logic [XLEN-1:0] exp_result;
   logic exp_exc, exp_commit, timed_out;
   logic [31:0] lfsr_state = 32'h2cc5_a844;
   int err_count, fail_tests, errs_before;
   int reqs_per_test = 200;
   string cur_test;

   lsu_ctl u_lsu_ctl (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ****************************************
   // Random source and reference rules
   // ****************************************
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // True with probability one in 2**n
   function automatic logic chance(input int n);
      logic [31:0] v;
      v = take_bits(n);
      return v == 32'h0;
   endfunction

   function automatic logic in_dccm(input logic [31:0] a);
      return (a >= DCCM_BASE) && (a < DCCM_BASE + DCCM_SIZE_BYTES);
   endfunction

   function automatic logic in_pic(input logic [31:0] a);
      return (a >= PIC_BASE) && (a < PIC_BASE + PIC_SIZE_BYTES);
   endfunction

   function automatic item_t build_item();
      item_t it;
      logic [31:0] off;
      it.dma   = dma_dccm_req;
      it.valid = (lsu_p.valid & ~flush_dc2_up) | dma_dccm_req;
      if (dma_dccm_req) begin
         off       = '0;
         it.addr   = dma_mem_addr;
         it.load   = ~dma_mem_write;
         it.unsign = 1'b0;
         case (dma_mem_sz[1:0])
            2'd0: it.szm1 = 3'd0;
            2'd1: it.szm1 = 3'd1;
            2'd2: it.szm1 = 3'd3;
            default: it.szm1 = 3'd7;
         endcase
         // Write data lands on the lane of the start byte
         it.wdata = dma_mem_wdata >> (32'(dma_mem_addr[2:0]) * 32'd8);
      end else begin
         off       = {{20{dec_lsu_offset_d[11]}}, dec_lsu_offset_d};
         it.addr   = exu_lsu_rs1_d;
         it.load   = lsu_p.load;
         it.unsign = lsu_p.unsign;
         it.szm1   = lsu_p.dword ? 3'd7 : lsu_p.word ? 3'd3 : lsu_p.half ? 3'd1 : 3'd0;
         it.wdata  = {32'h0, exu_lsu_rs2_d};
      end
      it.addr     = it.addr + off;
      it.end_addr = it.addr + {29'd0, it.szm1};
      it.ext      = !in_dccm(it.addr) && !in_pic(it.addr);
      it.afault   = (in_dccm(it.addr) != in_dccm(it.end_addr)) ||
                    (in_pic(it.addr) != in_pic(it.end_addr)) ||
                    (in_pic(it.addr) && it.szm1 != 3'd3);
      it.mfault   = ((it.addr[2:0] & it.szm1) != 3'd0) && !in_dccm(it.addr);
      return it;
   endfunction

   function automatic item_t kill_item(input item_t it, input logic kill);
      if (kill && !it.dma) begin
         it.valid = 1'b0;
      end
      return it;
   endfunction

   function automatic logic [31:0] format_load(input item_t it, input logic [31:0] ld,
                                               input logic [31:0] bus);
      logic [31:0] d;
      d = it.ext ? bus : ld;
      case (it.szm1)
         3'd0: return it.unsign ? {24'h0, d[7:0]} : {{24{d[7]}}, d[7:0]};
         3'd1: return it.unsign ? {16'h0, d[15:0]} : {{16{d[15]}}, d[15:0]};
         default: return d;
      endcase
   endfunction

   // Model pipeline, same flush points as the DUT stages
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i <= 5; i++) begin
            exp_q[i].valid <= 1'b0;
         end
      end else begin
         exp_q[1] <= build_item();
         exp_q[2] <= kill_item(exp_q[1], flush_dc2_up);
         exp_q[3] <= kill_item(exp_q[2], flush_dc2_up);
         exp_q[4] <= kill_item(exp_q[3], flush_dc3);
         exp_q[5] <= kill_item(exp_q[4], flush_dc4);
      end
   end

   always_comb begin
      exp_result = format_load(exp_q[3], lsu_ld_data_dc3, bus_read_data_dc3);
      exp_exc    = exp_q[3].valid && !exp_q[3].dma && !flush_dc3 &&
                   (exp_q[3].afault || exp_q[3].mfault || ld_bus_error_dc3);
      exp_commit = exp_q[5].valid && !exp_q[5].dma && !flush_dc5;
   end

   // ****************************************
   // Checks
   // ****************************************
   task automatic log_value(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      $display("ERR %s %s expected %h actual %h", cur_test, name, expected, actual);
      err_count++;
   endtask

   task automatic log_flag(input string name, input logic expected, input logic actual);
      $display("ERR %s %s expected %b actual %b", cur_test, name, expected, actual);
      err_count++;
   endtask

   a_dc3_valid : assert property (@(posedge clk) disable iff (rst)
      lsu_pkt_dc3.valid == exp_q[3].valid)
      else log_flag("dc3_valid", $sampled(exp_q[3].valid), $sampled(lsu_pkt_dc3.valid));
   a_addr : assert property (@(posedge clk) disable iff (rst)
      exp_q[3].valid |-> lsu_addr_dc3 == exp_q[3].addr)
      else log_value("addr_dc3", $sampled(exp_q[3].addr), $sampled(lsu_addr_dc3));
   a_end_addr : assert property (@(posedge clk) disable iff (rst)
      exp_q[3].valid |-> end_addr_dc3 == exp_q[3].end_addr)
      else log_value("end_addr_dc3", $sampled(exp_q[3].end_addr), $sampled(end_addr_dc3));
   a_store_data : assert property (@(posedge clk) disable iff (rst)
      exp_q[3].valid |-> store_data_dc3 == exp_q[3].wdata[31:0])
      else log_value("store_data_dc3", $sampled(exp_q[3].wdata[31:0]),
                     $sampled(store_data_dc3));
   a_dma_flag : assert property (@(posedge clk) disable iff (rst)
      exp_q[3].valid |-> lsu_pkt_dc3.dma == exp_q[3].dma)
      else log_flag("dma_dc3", $sampled(exp_q[3].dma), $sampled(lsu_pkt_dc3.dma));
   a_external : assert property (@(posedge clk) disable iff (rst)
      exp_q[3].valid |-> addr_external_dc3 == exp_q[3].ext)
      else log_flag("external_dc3", $sampled(exp_q[3].ext), $sampled(addr_external_dc3));
   a_result : assert property (@(posedge clk) disable iff (rst)
      (exp_q[3].valid && exp_q[3].load && !exp_q[3].dma) |-> lsu_result_dc3 == exp_result)
      else log_value("result_dc3", $sampled(exp_result), $sampled(lsu_result_dc3));
   a_exc_dc2 : assert property (@(posedge clk) disable iff (rst)
      exp_q[2].valid |-> lsu_exc_dc2 == (exp_q[2].afault || exp_q[2].mfault))
      else log_flag("exc_dc2", $sampled(exp_q[2].afault || exp_q[2].mfault),
                    $sampled(lsu_exc_dc2));
   a_exc_valid : assert property (@(posedge clk) disable iff (rst)
      lsu_error_pkt_dc3.exc_valid == exp_exc)
      else log_flag("exc_valid", $sampled(exp_exc), $sampled(lsu_error_pkt_dc3.exc_valid));
   a_exc_type : assert property (@(posedge clk) disable iff (rst)
      exp_exc |-> lsu_error_pkt_dc3.exc_type == !exp_q[3].mfault)
      else log_flag("exc_type", $sampled(!exp_q[3].mfault),
                    $sampled(lsu_error_pkt_dc3.exc_type));
   a_exc_inst : assert property (@(posedge clk) disable iff (rst)
      exp_exc |-> lsu_error_pkt_dc3.inst_type == !exp_q[3].load)
      else log_flag("exc_inst_type", $sampled(!exp_q[3].load),
                    $sampled(lsu_error_pkt_dc3.inst_type));
   a_exc_addr : assert property (@(posedge clk) disable iff (rst)
      exp_exc |-> lsu_error_pkt_dc3.addr == exp_q[3].addr)
      else log_value("exc_addr", $sampled(exp_q[3].addr), $sampled(lsu_error_pkt_dc3.addr));
   a_commit : assert property (@(posedge clk) disable iff (rst)
      lsu_commit_dc5 == exp_commit)
      else log_flag("commit_dc5", $sampled(exp_commit), $sampled(lsu_commit_dc5));
   a_commit_addr : assert property (@(posedge clk) disable iff (rst)
      exp_commit |-> lsu_addr_dc5 == exp_q[5].addr)
      else log_value("addr_dc5", $sampled(exp_q[5].addr), $sampled(lsu_addr_dc5));
   a_commit_data : assert property (@(posedge clk) disable iff (rst)
      exp_commit |-> store_data_dc5 == exp_q[5].wdata[31:0])
      else log_value("store_data_dc5", $sampled(exp_q[5].wdata[31:0]),
                     $sampled(store_data_dc5));

   // ****************************************
   // Stimulus
   // ****************************************
   // Region 3 lands just below a DCCM or PIC edge so wide accesses cross it
   function automatic logic [31:0] pick_addr(input logic [1:0] region);
      logic [31:0] r;
      logic [31:0] edge_addr;
      r = take_bits(2);
      case (r[1:0])
         2'd0: edge_addr = DCCM_BASE;
         2'd1: edge_addr = DCCM_BASE + DCCM_SIZE_BYTES;
         2'd2: edge_addr = PIC_BASE;
         default: edge_addr = PIC_BASE + PIC_SIZE_BYTES;
      endcase
      case (region)
         2'd0: return DCCM_BASE + take_bits(16);
         2'd1: return PIC_BASE + take_bits(15);
         2'd2: return take_bits(32);
         default: return edge_addr - 32'd1 - take_bits(3);
      endcase
   endfunction

   // Modes: 0 address, 1 load format, 2 DMA, 3 flush, 4 fault, 5 commit
   function automatic logic flush_draw(input int mode);
      case (mode)
         3: return chance(2);
         2, 4: return chance(3);
         5: return chance(4);
         default: return 1'b0;
      endcase
   endfunction

   task automatic drive_cycle(input int mode);
      logic [31:0] r;
      logic [31:0] target;
      logic [11:0] off;
      logic [2:0]  sz;
      lsu_pkt_t    p;
      r      = take_bits(2);
      target = pick_addr((mode == 4) ? {1'b1, r[0]} : r[1:0]);
      r      = take_bits(12);
      off    = r[11:0];
      r      = take_bits(5);
      sz     = {1'b0, r[4:3]};
      p          = '0;
      p.valid    = ~chance(2);
      p.by       = (r[1:0] == 2'd0);
      p.half     = (r[1:0] == 2'd1);
      p.word     = r[1];
      p.load     = (mode == 1) | r[2];
      p.store    = ~p.load;
      p.unsign   = chance(1) & p.load;
      @(posedge clk);
      lsu_p             <= p;
      exu_lsu_rs1_d     <= target - {{20{off[11]}}, off};
      dec_lsu_offset_d  <= off;
      exu_lsu_rs2_d     <= take_bits(32);
      lsu_ld_data_dc3   <= take_bits(32);
      bus_read_data_dc3 <= take_bits(32);
      ld_bus_error_dc3  <= (mode == 4) & chance(3);
      dma_dccm_req      <= ((mode == 2) & chance(1)) | ((mode == 5) & chance(3));
      dma_mem_addr      <= target;
      dma_mem_sz        <= sz;
      dma_mem_write     <= chance(1);
      dma_mem_wdata     <= {take_bits(32), take_bits(32)};
      flush_dc2_up      <= flush_draw(mode);
      flush_dc3         <= flush_draw(mode);
      flush_dc4         <= flush_draw(mode);
      flush_dc5         <= flush_draw(mode);
   endtask

   task automatic drive_idle();
      @(posedge clk);
      lsu_p            <= '0;
      dma_dccm_req     <= 1'b0;
      ld_bus_error_dc3 <= 1'b0;
      flush_dc2_up     <= 1'b0;
      flush_dc3        <= 1'b0;
      flush_dc4        <= 1'b0;
      flush_dc5        <= 1'b0;
   endtask

   function automatic logic pipe_busy();
      return exp_q[1].valid | exp_q[2].valid | exp_q[3].valid | exp_q[4].valid |
             exp_q[5].valid | lsu_pkt_dc3.valid | lsu_commit_dc5;
   endfunction

   task automatic drain_pipe();
      int cycles;
      cycles = 0;
      while (pipe_busy() && cycles < 20) begin
         @(posedge clk);
         cycles++;
      end
      if (pipe_busy()) begin
         $display("Pipeline still holds items after %0d idle cycles", cycles);
         timed_out = 1'b1;
      end
   endtask

   function automatic string test_name(input int t);
      case (t)
         0: return "address";
         1: return "load_format";
         2: return "dma";
         3: return "flush";
         4: return "fault";
         default: return "commit";
      endcase
   endfunction

   initial begin
      rst = 1'b1;
      lsu_p = '0;
      exu_lsu_rs1_d = '0;
      exu_lsu_rs2_d = '0;
      dec_lsu_offset_d = '0;
      dma_dccm_req = 1'b0;
      dma_mem_addr = '0;
      dma_mem_sz = '0;
      dma_mem_write = 1'b0;
      dma_mem_wdata = '0;
      {flush_dc2_up, flush_dc3, flush_dc4, flush_dc5} = '0;
      lsu_ld_data_dc3 = '0;
      bus_read_data_dc3 = '0;
      ld_bus_error_dc3 = 1'b0;
      err_count = 0;
      fail_tests = 0;
      timed_out = 1'b0;
      cur_test = "startup";
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      // A few idle cycles so commit is seen low before the first item
      drive_idle();
      drive_idle();
      for (int t = 0; t < 6; t++) begin
         if (!timed_out) begin
            errs_before = err_count;
            cur_test = test_name(t);
            repeat (reqs_per_test) drive_cycle(t);
            drive_idle();
            drain_pipe();
            if (err_count != errs_before || timed_out) begin
               fail_tests++;
            end
            $display("test %s: %0d requests, %0d errors", test_name(t), reqs_per_test,
                     err_count - errs_before);
         end
      end
      $display("tests run 6, tests with errors %0d, check errors %0d", fail_tests, err_count);
      if (err_count == 0 && !timed_out) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- lsu_ctl.f
src/lsu_pkg.sv
src/lsu_issue_stage.sv
src/lsu_addr_stage.sv
src/lsu_stage_reg.sv
src/lsu_result_stage.sv
src/lsu_ctl.sv
verification/lsu_ctl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module lsu_ctl_tb \
   -f lsu_ctl.f \
   -o lsu_ctl_sim

./obj_dir/lsu_ctl_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
   echo "Simulation run passed"
else
   echo "Simulation run failed"
   exit 1
fi
